// File: ch3_pkg.sv
package ch3_pkg;

	// field widths
	localparam int FREQ_W = 11;
	localparam int LEN_W  = 8;
	localparam int POS_W  = 5;

	typedef logic [FREQ_W-1:0] freq_t;  // NR33/NR34 frequency
	typedef logic [LEN_W-1:0]  len_t;   // NR31 length load
	typedef logic [POS_W-1:0]  pos_t;   // 32 samples per wave
	typedef logic [3:0]        sample_t;
	typedef logic [7:0]        byte_t;

	// 0 mute, 1 full, 2 half, 3 quarter
	typedef logic [1:0] vol_t;

	// channel register map
	localparam logic [15:0] ADDR_NR30 = 16'hff1a; // dac enable
	localparam logic [15:0] ADDR_NR31 = 16'hff1b; // length load
	localparam logic [15:0] ADDR_NR32 = 16'hff1c; // volume
	localparam logic [15:0] ADDR_NR33 = 16'hff1d; // freq low
	localparam logic [15:0] ADDR_NR34 = 16'hff1e; // trigger, len enable, freq high

	// 16 byte wave ram
	localparam logic [15:0] ADDR_WAVE_BASE = 16'hff30;

	// unused bits read back as one
	localparam byte_t MASK_NR30 = 8'h7f;
	localparam byte_t MASK_NR32 = 8'h9f;
	localparam byte_t MASK_NR34 = 8'hbf;

endpackage

// File: ch3_reload_counter.sv
`timescale 1ns/1ps

module ch3_reload_counter #(
		parameter type count_t = logic [7:0]
	) (
		input  logic   cery_2mhz,
		input  logic   reset,
		input  logic   load,
		input  count_t load_val,
		input  logic   step,
		output logic   wrap
	);

	count_t count;
	logic   at_top;

	assign at_top = (count == '1);

	// no wrap pulse on a load cycle
	assign wrap = step && at_top && !load;

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= load_val;
		end else if (step) begin
			if (at_top)
				count <= load_val; // reload on wrap
			else
				count <= count_t'(count + 1'b1);
		end
	end

endmodule

// File: ch3_wave_ram.sv
`timescale 1ns/1ps

module ch3_wave_ram
	import ch3_pkg::*;
	(
		input  logic       cery_2mhz,
		input  logic       ram_wr,
		input  logic [3:0] ram_widx,
		input  byte_t      wdata,
		input  logic [3:0] addr_idx,
		input  logic       ch3_active,
		input  pos_t       wave_pos,
		output byte_t      ram_rdata
	);

	byte_t      mem [16];
	logic [3:0] rd_idx;

	// playing channel owns the read port
	assign rd_idx = ch3_active ? wave_pos[POS_W-1:1] : addr_idx;

	always_ff @(posedge cery_2mhz) begin
		if (ram_wr)
			mem[ram_widx] <= wdata;
	end

	assign ram_rdata = mem[rd_idx]; // async read

endmodule

// File: ch3_reg_decode.sv
`timescale 1ns/1ps

module ch3_reg_decode
	import ch3_pkg::*;
	(
		input  logic        cery_2mhz,
		input  logic        reset,
		input  logic [15:0] addr,
		input  byte_t       wdata,
		input  logic        wr_en,
		input  logic        rd_en,
		input  byte_t       ram_rdata,
		input  logic        ch3_active,
		output byte_t       rdata,
		output logic        dac_en,
		output freq_t       freq,
		output len_t        len_load,
		output logic        len_wr,
		output logic        len_en,
		output logic        trigger,
		output vol_t        volume,
		output logic        ram_wr,
		output logic [3:0]  ram_widx
	);

	logic  wave_sel;
	logic  sel_nr31;
	logic  sel_nr34;
	byte_t rd_mux;

	assign wave_sel = (addr[15:4] == ADDR_WAVE_BASE[15:4]);
	assign sel_nr31 = (addr == ADDR_NR31);
	assign sel_nr34 = (addr == ADDR_NR34);

	// wave ram writes go straight through
	assign ram_wr   = wr_en && wave_sel;
	assign ram_widx = addr[3:0];

	// register file and strobes
	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			dac_en   <= 1'b0;
			len_load <= '0;
			volume   <= '0;
			freq     <= '0;
			len_en   <= 1'b0;
			trigger  <= 1'b0;
			len_wr   <= 1'b0;
		end else begin
			// strobes land one edge after the write
			trigger <= wr_en && sel_nr34 && wdata[7];
			len_wr  <= wr_en && sel_nr31;
			if (wr_en) begin
				case (addr)
					ADDR_NR30: dac_en <= wdata[7];
					ADDR_NR31: len_load <= wdata;
					ADDR_NR32: volume <= wdata[6:5];
					ADDR_NR33: freq[7:0] <= wdata;
					ADDR_NR34: begin
						freq[FREQ_W-1:8] <= wdata[2:0];
						len_en           <= wdata[6];
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (addr)
			ADDR_NR30: rd_mux = {dac_en, 7'b0} | MASK_NR30;
			ADDR_NR32: rd_mux = {1'b0, volume, 5'b0} | MASK_NR32;
			ADDR_NR34: rd_mux = {ch3_active, len_en, 6'b0} | MASK_NR34; // bit 7 masked
			default: begin
				if (wave_sel)
					rd_mux = ram_rdata; // playing byte while active
				else
					rd_mux = '1; // write-only or unmapped
			end
		endcase
	end

	always_ff @(posedge cery_2mhz) begin
		if (reset)
			rdata <= '0;
		else if (rd_en)
			rdata <= rd_mux;
	end

endmodule

// File: ch3_wave_sequencer.sv
`timescale 1ns/1ps

module ch3_wave_sequencer
	import ch3_pkg::*;
	(
		input  logic  cery_2mhz,
		input  logic  reset,
		input  logic  dac_en,
		input  freq_t freq,
		input  len_t  len_load,
		input  logic  len_wr,
		input  logic  len_en,
		input  logic  trigger,
		input  logic  frame_256hz,
		output logic  ch3_active,
		output pos_t  wave_pos
	);

	logic start;
	logic freq_wrap;
	logic len_wrap;
	logic len_expired;
	logic len_reload;
	logic len_ld;
	len_t len_ld_val;
	logic len_step;

	// trigger only counts with the dac powered
	assign start = trigger && dac_en;

	// expired length restarts from zero on trigger
	assign len_reload = start && len_expired;
	assign len_ld     = len_wr || len_reload;
	assign len_ld_val = len_reload ? len_t'(0) : len_load;
	assign len_step   = len_en && frame_256hz && !len_expired; // frozen once expired

	ch3_reload_counter #(
		.count_t(freq_t)
	) freq_timer_i (
		.cery_2mhz(cery_2mhz),
		.reset    (reset),
		.load     (start),
		.load_val (freq),
		.step     (ch3_active),
		.wrap     (freq_wrap)
	);

	ch3_reload_counter #(
		.count_t(len_t)
	) length_ctr_i (
		.cery_2mhz(cery_2mhz),
		.reset    (reset),
		.load     (len_ld),
		.load_val (len_ld_val),
		.step     (len_step),
		.wrap     (len_wrap)
	);

	always_ff @(posedge cery_2mhz) begin
		if (reset)
			len_expired <= 1'b0;
		else if (len_ld)
			len_expired <= 1'b0;
		else if (len_wrap)
			len_expired <= 1'b1;
	end

	// active flag and sample position
	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			ch3_active <= 1'b0;
			wave_pos   <= '0;
		end else if (start) begin
			ch3_active <= 1'b1;
			wave_pos   <= '0;
		end else if (!dac_en || len_wrap) begin
			ch3_active <= 1'b0; // dac off or length ran out
		end else if (freq_wrap) begin
			wave_pos <= pos_t'(wave_pos + 1'b1); // mod 32
		end
	end

endmodule

// File: ch3_volume_dac.sv
`timescale 1ns/1ps

module ch3_volume_dac
	import ch3_pkg::*;
	(
		input  logic    cery_2mhz,
		input  logic    reset,
		input  byte_t   ram_rdata,
		input  pos_t    wave_pos,
		input  vol_t    volume,
		input  logic    ch3_active,
		output sample_t dac_out
	);

	sample_t nibble;
	sample_t shifted;

	// even position plays the high nibble first
	assign nibble = wave_pos[0] ? ram_rdata[3:0] : ram_rdata[7:4];

	always_comb begin
		case (volume)
			2'd0: shifted = '0; // mute
			2'd1: shifted = nibble;
			2'd2: shifted = nibble >> 1;
			default: shifted = nibble >> 2;
		endcase
	end

	always_ff @(posedge cery_2mhz) begin
		if (reset)
			dac_out <= '0;
		else
			dac_out <= ch3_active ? shifted : sample_t'(0);
	end

endmodule

// File: ch3_wave_channel.sv
`timescale 1ns/1ps

module ch3_wave_channel
	import ch3_pkg::*;
	(
		input  logic        cery_2mhz,
		input  logic        reset,
		input  logic [15:0] addr,
		input  byte_t       wdata,
		input  logic        wr_en,
		input  logic        rd_en,
		output byte_t       rdata,
		input  logic        frame_256hz,
		output logic        ch3_active,
		output pos_t        wave_pos,
		output sample_t     dac_out
	);

	logic       dac_en;
	freq_t      freq;
	len_t       len_load;
	logic       len_wr;
	logic       len_en;
	logic       trigger;
	vol_t       volume;
	logic       ram_wr;
	logic [3:0] ram_widx;
	byte_t      ram_rdata;

	ch3_reg_decode decode_i (
		.cery_2mhz (cery_2mhz),
		.reset     (reset),
		.addr      (addr),
		.wdata     (wdata),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.ram_rdata (ram_rdata),
		.ch3_active(ch3_active),
		.rdata     (rdata),
		.dac_en    (dac_en),
		.freq      (freq),
		.len_load  (len_load),
		.len_wr    (len_wr),
		.len_en    (len_en),
		.trigger   (trigger),
		.volume    (volume),
		.ram_wr    (ram_wr),
		.ram_widx  (ram_widx)
	);

	ch3_wave_ram ram_i (
		.cery_2mhz (cery_2mhz),
		.ram_wr    (ram_wr),
		.ram_widx  (ram_widx),
		.wdata     (wdata),
		.addr_idx  (addr[3:0]),
		.ch3_active(ch3_active),
		.wave_pos  (wave_pos),
		.ram_rdata (ram_rdata)
	);

	ch3_wave_sequencer seq_i (
		.cery_2mhz  (cery_2mhz),
		.reset      (reset),
		.dac_en     (dac_en),
		.freq       (freq),
		.len_load   (len_load),
		.len_wr     (len_wr),
		.len_en     (len_en),
		.trigger    (trigger),
		.frame_256hz(frame_256hz),
		.ch3_active (ch3_active),
		.wave_pos   (wave_pos)
	);

	ch3_volume_dac dac_i (
		.cery_2mhz (cery_2mhz),
		.reset     (reset),
		.ram_rdata (ram_rdata),
		.wave_pos  (wave_pos),
		.volume    (volume),
		.ch3_active(ch3_active),
		.dac_out   (dac_out)
	);

endmodule

// File: ch3_wave_channel_sva.sv
`timescale 1ns/1ps

module ch3_wave_channel_sva
	import ch3_pkg::*;
	(
		input logic    cery_2mhz,
		input logic    reset,
		input logic    ch3_active,
		input logic    trigger,
		input logic    dac_en,
		input pos_t    wave_pos,
		input sample_t dac_out,
		input byte_t   rdata
	);

	int assert_fails = 0;

	idle_silent: assert property (@(posedge cery_2mhz) disable iff (reset)
		!ch3_active |=> (dac_out == '0))
		else begin
			assert_fails++;
			$error("dac_out not zero one cycle after an inactive cycle");
		end

	// only a started trigger may jump back to zero
	pos_step: assert property (@(posedge cery_2mhz) disable iff (reset)
		(wave_pos != $past(wave_pos)) |->
			((wave_pos == pos_t'($past(wave_pos) + 1'b1)) ||
			($past(trigger && dac_en) && (wave_pos == '0))))
		else begin
			assert_fails++;
			$error("wave_pos moved from %0d to %0d", $past(wave_pos), wave_pos);
		end

	reset_clear: assert property (@(posedge cery_2mhz)
		reset |=> (!ch3_active && (dac_out == '0) && (wave_pos == '0) && (rdata == '0)))
		else begin
			assert_fails++;
			$error("outputs not cleared the cycle after reset");
		end

endmodule

bind ch3_wave_channel ch3_wave_channel_sva sva_i (
	.cery_2mhz (cery_2mhz),
	.reset     (reset),
	.ch3_active(ch3_active),
	.trigger   (trigger),
	.dac_en    (dac_en),
	.wave_pos  (wave_pos),
	.dac_out   (dac_out),
	.rdata     (rdata)
);

// File: tb_ch3_wave_channel.sv
`timescale 1ns/1ps

module tb_ch3_wave_channel
	import ch3_pkg::*;
	();

	localparam int OP_RW      = 0; // write then read back
	localparam int OP_PLAY    = 1;
	localparam int OP_LEN     = 2;
	localparam int OP_NODAC   = 3;
	localparam int NUM_ROWS   = 15;
	localparam int PLAY_STEPS = 34; // runs past the end of the wave

	typedef struct {
		int          op;
		logic [15:0] addr;
		byte_t       wdata;
		byte_t       exp_rd;
		vol_t        volume;
		freq_t       freq;
		len_t        length;
	} row_t;

	// op, addr, wdata, expected read, volume, freq, length
	row_t rows [NUM_ROWS] = '{
		'{OP_RW,    ADDR_NR30, 8'h80, 8'hff, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR30, 8'h00, 8'h7f, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR31, 8'h55, 8'hff, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR32, 8'h20, 8'hbf, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR32, 8'h60, 8'hff, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR33, 8'h12, 8'hff, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR34, 8'h40, 8'hff, 2'd0, 11'd0,    8'h00},
		'{OP_RW,    ADDR_NR34, 8'h07, 8'hbf, 2'd0, 11'd0,    8'h00},
		'{OP_PLAY,  16'h0000,  8'h00, 8'h00, 2'd0, 11'd2040, 8'h00},
		'{OP_PLAY,  16'h0000,  8'h00, 8'h00, 2'd1, 11'd2000, 8'h00},
		'{OP_PLAY,  16'h0000,  8'h00, 8'h00, 2'd2, 11'd1280, 8'h00},
		'{OP_PLAY,  16'h0000,  8'h00, 8'h00, 2'd3, 11'd2044, 8'h00},
		'{OP_LEN,   16'h0000,  8'h00, 8'h00, 2'd1, 11'h700,  8'hf0},
		'{OP_LEN,   16'h0000,  8'h00, 8'h00, 2'd1, 11'h700,  8'h00},
		'{OP_NODAC, 16'h0000,  8'h00, 8'h00, 2'd0, 11'd0,    8'h00}
	};

	logic        cery_2mhz = 1'b0;
	logic        reset;
	logic [15:0] addr;
	byte_t       wdata;
	logic        wr_en;
	logic        rd_en;
	logic        frame_256hz;
	byte_t       rdata;
	logic        ch3_active;
	pos_t        wave_pos;
	sample_t     dac_out;
	byte_t       ram_model [16];
	int          budget_cycles = 0;

	ch3_wave_channel dut_i (.*);

	always #4 cery_2mhz = ~cery_2mhz;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %0t %s expected %02h got %02h", $time, name, exp, act));
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %0t %s expected %0h got %0h", $time, name, exp, act));
	endtask

	task automatic check_pos(input string name, input pos_t exp, input pos_t act);
		if (act !== exp)
			fail_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic tick();
		@(posedge cery_2mhz);
		#1; // drive point after the edge
	endtask

	task automatic write_reg(input logic [15:0] a, input byte_t d);
		addr  = a;
		wdata = d;
		wr_en = 1'b1;
		tick();
		wr_en = 1'b0;
	endtask

	task automatic read_check(input logic [15:0] a, input byte_t exp);
		addr  = a;
		rd_en = 1'b1;
		tick();
		rd_en = 1'b0;
		check_byte("rdata", exp, rdata);
	endtask

	task automatic wait_active(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (ch3_active !== level) begin
			if (n == max_cycles) begin
				fail_run($sformatf("ch3_active never went to %b within %0d cycles",
					level, max_cycles));
			end else begin
				tick();
				n++;
			end
		end
	endtask

	function automatic sample_t expected_sample(input byte_t b, input pos_t pos, input vol_t vol);
		sample_t nib;
		int      shift;
		nib = pos[0] ? b[3:0] : b[7:4]; // even position is the upper nibble
		case (vol)
			2'd0: shift = 4;
			2'd1: shift = 0;
			2'd2: shift = 1;
			default: shift = 2;
		endcase
		return nib >> shift;
	endfunction

	task automatic start_channel(input vol_t vol, input freq_t f, input logic len_on);
		write_reg(ADDR_NR30, 8'h80);
		write_reg(ADDR_NR32, {1'b0, vol, 5'b0});
		write_reg(ADDR_NR33, f[7:0]);
		write_reg(ADDR_NR34, {1'b1, len_on, 3'b0, f[10:8]});
		wait_active(1'b1, 4);
	endtask

	task automatic play_row(input row_t r);
		pos_t  last;
		byte_t rd_exp;
		int    period;
		int    gap;
		int    steps;
		logic  dac_due;
		period = 2048 - r.freq;
		start_channel(r.volume, r.freq, 1'b0);
		check_pos("wave_pos", 5'd0, wave_pos);
		last    = wave_pos;
		gap     = 0;
		steps   = 0;
		dac_due = 1'b1;
		addr    = ADDR_WAVE_BASE;
		rd_en   = 1'b1;
		rd_exp  = ram_model[wave_pos[4:1]];
		while (steps < PLAY_STEPS || dac_due) begin
			tick();
			gap++;
			check_byte("rdata", rd_exp, rdata); // playing byte at any address
			if (dac_due) begin
				check_sample("dac_out", expected_sample(ram_model[last[4:1]], last, r.volume),
					dac_out);
				dac_due = 1'b0;
			end
			if (wave_pos !== last) begin
				check_pos("wave_pos", pos_t'(last + 1'b1), wave_pos);
				if (gap != period)
					fail_run($sformatf("ERR %0t sample_period expected %0d got %0d",
						$time, period, gap));
				last    = wave_pos;
				gap     = 0;
				dac_due = 1'b1;
				steps++;
			end else if (gap > period) begin
				fail_run("wave_pos stopped advancing during playback");
			end
			addr   = {ADDR_WAVE_BASE[15:4], 4'(gap)};
			rd_exp = ram_model[wave_pos[4:1]];
		end
		rd_en = 1'b0;
		// dac off stops the channel
		write_reg(ADDR_NR30, 8'h00);
		wait_active(1'b0, 2);
		tick();
		check_sample("dac_out", 4'd0, dac_out);
	endtask

	task automatic len_row(input row_t r);
		int pulses;
		pulses = 256 - r.length;
		write_reg(ADDR_NR31, r.length);
		start_channel(r.volume, r.freq, 1'b1);
		for (int n = 1; n <= pulses; n++) begin
			frame_256hz = 1'b1;
			tick();
			frame_256hz = 1'b0;
			check_bit("ch3_active", n < pulses, ch3_active);
			tick();
		end
	endtask

	function automatic int row_cycles(input row_t r);
		case (r.op)
			OP_RW: return 4;
			OP_PLAY: return (PLAY_STEPS + 1) * (2048 - r.freq) + 20;
			OP_LEN: return 2 * (256 - r.length) + 20;
			default: return 20;
		endcase
	endfunction

	always @(posedge cery_2mhz) begin
		if (dut_i.sva_i.assert_fails != 0)
			fail_run("an assertion in ch3_wave_channel_sva failed");
	end

	initial begin
		wait (budget_cycles != 0);
		repeat (budget_cycles) @(posedge cery_2mhz);
		fail_run($sformatf("timeout, run still going after %0d cycles", budget_cycles));
	end

	initial begin
		reset       = 1'b1;
		addr        = '0;
		wdata       = '0;
		wr_en       = 1'b0;
		rd_en       = 1'b0;
		frame_256hz = 1'b0;
		void'($urandom(32'h43c2f801));
		budget_cycles = 300; // reset, ram fill and slack
		foreach (rows[i])
			budget_cycles += row_cycles(rows[i]);
		repeat (10) @(posedge cery_2mhz);
		#1;
		reset = 1'b0;

		check_bit("ch3_active", 1'b0, ch3_active);
		check_sample("dac_out", 4'd0, dac_out);
		check_pos("wave_pos", 5'd0, wave_pos);
		read_check(ADDR_NR30, 8'h7f);

		// random wave read back while idle
		for (int i = 0; i < 16; i++) begin
			ram_model[i] = byte_t'($urandom);
			write_reg(ADDR_WAVE_BASE + 16'(i), ram_model[i]);
		end
		for (int i = 0; i < 16; i++)
			read_check(ADDR_WAVE_BASE + 16'(i), ram_model[i]);

		foreach (rows[i]) begin
			case (rows[i].op)
				OP_RW: begin
					write_reg(rows[i].addr, rows[i].wdata);
					read_check(rows[i].addr, rows[i].exp_rd);
				end
				OP_PLAY: play_row(rows[i]);
				OP_LEN: len_row(rows[i]);
				default: begin
					write_reg(ADDR_NR30, 8'h00);
					write_reg(ADDR_NR34, 8'h87); // trigger with dac off
					repeat (6) begin
						tick();
						check_bit("ch3_active", 1'b0, ch3_active);
					end
				end
			endcase
		end

		if (dut_i.sva_i.assert_fails == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

// File: ch3_wave_channel.f
ch3_pkg.sv
ch3_reload_counter.sv
ch3_wave_ram.sv
ch3_reg_decode.sv
ch3_wave_sequencer.sv
ch3_volume_dac.sv
ch3_wave_channel.sv
ch3_wave_channel_sva.sv
tb_ch3_wave_channel.sv
